//--- project.f
+incdir+rtl
rtl/fm_pkg.sv
rtl/fm_slot_counter.sv
rtl/fm_write_seq.sv
rtl/fm_op_regs.sv
rtl/fm_chan_regs.sv
rtl/fm_keyon.sv
rtl/fm_reg_top.sv
bench/fm_reg_tb.sv

//--- Makefile
TOP = fm_reg_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

//--- bench/fm_reg_tb.sv
// FM register bank testbench
`timescale 1ns/1ps
`default_nettype none
`include "fm_config.svh"

module fm_reg_tb;

    // one host write, then an optional CSM overflow and an optional write while busy
    typedef struct packed {
        logic       part;
        logic [7:0] addr;
        logic [7:0] data;
        logic       csm;
        logic       busy_wr;
    } entry_t;

    localparam int NUM_ENTRIES    = 22;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 100 + 500;

    logic                 clk;
    logic                 reset;
    logic                 wr;
    logic [8:0]           addr;
    logic [7:0]           din;
    logic                 csm;
    logic                 overflow_a;
    logic                 busy;
    fm_pkg::slot_t        slot;
    logic                 round_start;
    fm_pkg::op_params_t   op_params;
    fm_pkg::chan_params_t chan_params;
    logic                 keyon;

    // reference register map, indexed by position in the round
    fm_pkg::op_params_t   op_model   [0:`FM_NUM_SLOTS-1];
    fm_pkg::chan_params_t chan_model [0:`FM_NUM_CH-1];
    logic                 key_model  [0:`FM_NUM_SLOTS-1];
    logic [7:0]           hi_model;

    entry_t      table_entries [0:NUM_ENTRIES-1];
    int          slot_errs   = 0;
    int          op_errs     = 0;
    int          chan_errs   = 0;
    int          flag_errs   = 0;
    int          other_errs  = 0;
    int          cycle_count = 0;

    fm_reg_top UUT (
        .clk         (clk),
        .reset       (reset),
        .wr          (wr),
        .addr        (addr),
        .din         (din),
        .csm         (csm),
        .overflow_a  (overflow_a),
        .busy        (busy),
        .slot        (slot),
        .round_start (round_start),
        .op_params   (op_params),
        .chan_params (chan_params),
        .keyon       (keyon)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int chan_pos(input fm_pkg::ch_idx_t ch);
        return (ch[2] ? 3 : 0) + int'(ch[1:0]);
    endfunction

    function automatic int slot_pos(input fm_pkg::op_idx_t op, input fm_pkg::ch_idx_t ch);
        return int'(op) * 6 + chan_pos(ch);
    endfunction

    // k-th slot of a round, six channel codes per operator
    function automatic fm_pkg::slot_t expected_slot(input int k);
        fm_pkg::slot_t s;
        s.op = 2'(k / 6);
        s.ch = 3'((k % 6 < 3) ? k % 6 : k % 6 + 1);
        return s;
    endfunction

    // key data bit per operator slot code, slots run op1 op3 op2 op4
    function automatic int key_bit(input int op_code);
        case (op_code)
            0: return 4;
            1: return 6;
            2: return 5;
            default: return 7;
        endcase
    endfunction

    function automatic logic [7:0] rand_byte();
        return 8'($urandom);
    endfunction

    function automatic int total_errors();
        return slot_errs + op_errs + chan_errs + flag_errs + other_errs;
    endfunction

    task automatic print_counts();
        $display("errors: slot %0d, op %0d, chan %0d, flag %0d, other %0d",
                 slot_errs, op_errs, chan_errs, flag_errs, other_errs);
    endtask

    task automatic check_slot(input fm_pkg::slot_t got, input fm_pkg::slot_t exp);
        if (got !== exp) begin
            slot_errs++;
            $display("ERR slot got %h exp %h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_op(input fm_pkg::slot_t s, input fm_pkg::op_params_t got,
                            input fm_pkg::op_params_t exp);
        if (got !== exp) begin
            op_errs++;
            $display("ERR op_params op %h ch %h got %h exp %h", s.op, s.ch, got, exp);
        end
    endtask

    task automatic check_chan(input fm_pkg::slot_t s, input fm_pkg::chan_params_t got,
                              input fm_pkg::chan_params_t exp);
        if (got !== exp) begin
            chan_errs++;
            $display("ERR chan_params op %h ch %h got %h exp %h", s.op, s.ch, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errs++;
            $display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
        end
    endtask

    // register map rules applied to the model
    task automatic update_model(input entry_t e);
        fm_pkg::ch_idx_t ch;
        int              p;
        int              c;
        ch = {e.part, e.addr[1:0]};
        p  = slot_pos(e.addr[3:2], ch);
        c  = chan_pos(ch);
        if (e.addr == `FM_ADDR_KEYON) begin
            if (e.data[1:0] != 2'b11) begin
                for (int o = 0; o < 4; o++) begin
                    key_model[slot_pos(2'(o), e.data[2:0])] = e.data[key_bit(o)];
                end
            end
        end else if ({e.addr[7:2], 2'b00} == `FM_ADDR_FNUM_HI) begin
            hi_model = e.data;
        end else if (e.addr[1:0] != 2'b11) begin
            case (e.addr[7:4])
                `FM_GRP_DT1_MUL: begin
                    op_model[p].dt1 = e.data[6:4];
                    op_model[p].mul = e.data[3:0];
                end
                `FM_GRP_TL: op_model[p].tl = e.data[6:0];
                `FM_GRP_KS_AR: begin
                    op_model[p].ks = e.data[7:6];
                    op_model[p].ar = e.data[4:0];
                end
                `FM_GRP_AM_D1R: begin
                    op_model[p].amen = e.data[7];
                    op_model[p].d1r  = e.data[4:0];
                end
                `FM_GRP_D2R: op_model[p].d2r = e.data[4:0];
                `FM_GRP_SL_RR: begin
                    op_model[p].sl = e.data[7:4];
                    op_model[p].rr = e.data[3:0];
                end
                `FM_GRP_SSG: op_model[p].ssg = e.data[3:0];
                default: begin
                    if ({e.addr[7:2], 2'b00} == `FM_ADDR_FNUM_LO) begin
                        chan_model[c].fnum  = {hi_model[2:0], e.data};
                        chan_model[c].block = hi_model[5:3];
                    end else if ({e.addr[7:2], 2'b00} == `FM_ADDR_FB_ALG) begin
                        chan_model[c].fb  = e.data[5:3];
                        chan_model[c].alg = e.data[2:0];
                    end else if ({e.addr[7:2], 2'b00} == `FM_ADDR_PAN_MOD) begin
                        chan_model[c].rl  = e.data[7:6];
                        chan_model[c].ams = e.data[5:4];
                        chan_model[c].pms = e.data[2:0];
                    end
                end
            endcase
        end
    endtask

    task automatic host_write(input logic part, input logic [7:0] a, input logic [7:0] d);
        wr   = 1'b1;
        addr = {part, a};
        din  = d;
        @(negedge clk);
        wr = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy) begin
            @(negedge clk);
            n++;
        end
        if (n > 48) begin
            other_errs++;
            $display("busy stayed high for %0d cycles, more than two rounds", n);
        end
    endtask

    task automatic wait_rounds(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            if (round_start) begin
                seen++;
            end
            @(negedge clk);
        end
    endtask

    // compare every slot of the next round with the model
    task automatic observe_round(input logic csm_force);
        fm_pkg::slot_t s;
        while (!round_start) begin
            @(negedge clk);
        end
        for (int i = 0; i < `FM_NUM_SLOTS; i++) begin
            s = expected_slot(i);
            check_slot(slot, s);
            check_flag("round_start", round_start, i == 0);
            check_flag("busy", busy, 1'b0);
            check_op(s, op_params, op_model[i]);
            check_chan(s, chan_params, chan_model[chan_pos(s.ch)]);
            check_flag("keyon", keyon, key_model[i] | (csm_force && s.ch == 3'd2));
            if (i < `FM_NUM_SLOTS - 1) begin
                @(negedge clk);
            end
        end
    endtask

    // overflow pulse early in a round, away from round_start
    task automatic csm_pulse();
        while (!round_start) begin
            @(negedge clk);
        end
        @(negedge clk);
        csm        = 1'b1;
        overflow_a = 1'b1;
        @(negedge clk);
        csm        = 1'b0;
        overflow_a = 1'b0;
    endtask

    task automatic apply_entry(input entry_t e);
        logic is_key;
        logic quiet;
        is_key = (e.addr == `FM_ADDR_KEYON);
        quiet  = is_key || ({e.addr[7:2], 2'b00} == `FM_ADDR_FNUM_HI);
        wait_idle();
        host_write(e.part, e.addr, e.data);
        update_model(e);
        // key and high byte writes finish without a sweep
        check_flag("busy", busy, !quiet);
        if (e.busy_wr) begin
            host_write(e.part, e.addr, ~e.data);
        end
        wait_idle();
        if (is_key) begin
            wait_rounds(3);
        end
        observe_round(1'b0);
        if (e.csm) begin
            csm_pulse();
            observe_round(1'b1);
            observe_round(1'b0);
        end
    endtask

    task automatic build_table();
        // operator groups, two writes on unused channel codes
        table_entries[0]  = '{1'b0, 8'h30, rand_byte(), 1'b0, 1'b0};
        table_entries[1]  = '{1'b1, 8'h45, rand_byte(), 1'b0, 1'b1};
        table_entries[2]  = '{1'b0, 8'h5A, rand_byte(), 1'b0, 1'b0};
        table_entries[3]  = '{1'b1, 8'h6C, rand_byte(), 1'b0, 1'b0};
        table_entries[4]  = '{1'b0, 8'h71, rand_byte(), 1'b0, 1'b0};
        table_entries[5]  = '{1'b1, 8'h86, rand_byte(), 1'b0, 1'b0};
        table_entries[6]  = '{1'b0, 8'h9E, rand_byte(), 1'b1, 1'b0};
        table_entries[7]  = '{1'b0, 8'h33, rand_byte(), 1'b0, 1'b0};
        table_entries[8]  = '{1'b1, 8'h4B, rand_byte(), 1'b0, 1'b0};
        table_entries[9]  = '{1'b0, 8'h38, rand_byte(), 1'b0, 1'b0};
        // channel registers, high byte before low byte
        table_entries[10] = '{1'b0, 8'hA4, rand_byte(), 1'b0, 1'b0};
        table_entries[11] = '{1'b0, 8'hA0, rand_byte(), 1'b0, 1'b0};
        table_entries[12] = '{1'b1, 8'hA6, rand_byte(), 1'b0, 1'b0};
        table_entries[13] = '{1'b1, 8'hA2, rand_byte(), 1'b0, 1'b0};
        table_entries[14] = '{1'b0, 8'hB1, rand_byte(), 1'b0, 1'b1};
        table_entries[15] = '{1'b1, 8'hB4, rand_byte(), 1'b0, 1'b0};
        table_entries[16] = '{1'b0, 8'hB6, rand_byte(), 1'b0, 1'b0};
        table_entries[17] = '{1'b0, 8'hA3, rand_byte(), 1'b0, 1'b0};
        // key-on, operator mask in bits 7:4 and channel code in 2:0
        table_entries[18] = '{1'b0, `FM_ADDR_KEYON, 8'hF0, 1'b0, 1'b0};
        table_entries[19] = '{1'b0, `FM_ADDR_KEYON, (rand_byte() & 8'hF0) | 8'h05, 1'b1, 1'b0};
        table_entries[20] = '{1'b0, `FM_ADDR_KEYON, (rand_byte() & 8'hF0) | 8'h06, 1'b0, 1'b0};
        table_entries[21] = '{1'b0, `FM_ADDR_KEYON, 8'h00, 1'b0, 1'b0};
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            print_counts();
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        reset      = 1'b1;
        wr         = 1'b0;
        addr       = '0;
        din        = '0;
        csm        = 1'b0;
        overflow_a = 1'b0;
        hi_model   = '0;
        void'($urandom(32'h69bd));
        for (int i = 0; i < `FM_NUM_SLOTS; i++) begin
            op_model[i]  = '0;
            key_model[i] = 1'b0;
        end
        for (int i = 0; i < `FM_NUM_CH; i++) begin
            chan_model[i]    = '0;
            chan_model[i].rl = 2'd3;
        end
        build_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // reset values and slot order over the first round
        observe_round(1'b0);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            apply_entry(table_entries[i]);
        end
        print_counts();
        if (total_errors() == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/fm_reg_top.sv
// FM register bank top level
`timescale 1ns/1ps
`default_nettype none

module fm_reg_top (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       wr,
    input  wire  [8:0]                addr,
    input  wire  [7:0]                din,
    input  wire                       csm,
    input  wire                       overflow_a,
    output wire                       busy,
    output wire fm_pkg::slot_t        slot,
    output wire                       round_start,
    output wire fm_pkg::op_params_t   op_params,
    output wire fm_pkg::chan_params_t chan_params,
    output wire                       keyon
);

    wire fm_pkg::update_t upd;
    wire                  keyon_wr;
    wire [7:0]            keyon_data;

    fm_slot_counter u_slot_counter (
        .clk         (clk),
        .reset       (reset),
        .slot        (slot),
        .round_start (round_start)
    );

    fm_write_seq u_write_seq (
        .clk         (clk),
        .reset       (reset),
        .wr          (wr),
        .addr        (addr),
        .din         (din),
        .busy        (busy),
        .upd         (upd),
        .keyon_wr    (keyon_wr),
        .keyon_data  (keyon_data),
        .round_start (round_start)
    );

    fm_op_regs u_op_regs (
        .clk       (clk),
        .reset     (reset),
        .slot      (slot),
        .upd       (upd),
        .op_params (op_params)
    );

    fm_chan_regs u_chan_regs (
        .clk         (clk),
        .reset       (reset),
        .slot        (slot),
        .upd         (upd),
        .chan_params (chan_params)
    );

    fm_keyon u_keyon (
        .clk         (clk),
        .reset       (reset),
        .csm         (csm),
        .overflow_a  (overflow_a),
        .keyon_wr    (keyon_wr),
        .keyon_data  (keyon_data),
        .slot        (slot),
        .round_start (round_start),
        .keyon       (keyon)
    );

endmodule

`default_nettype wire

//--- rtl/fm_keyon.sv
// Key-on ring
`timescale 1ns/1ps
`default_nettype none
`include "fm_config.svh"

module fm_keyon (
    input  wire                clk,
    input  wire                reset,
    input  wire                csm,
    input  wire                overflow_a,
    input  wire                keyon_wr,
    input  wire  [7:0]         keyon_data,
    input  wire fm_pkg::slot_t slot,
    input  wire                round_start,
    output logic               keyon
);

    logic [`FM_NUM_SLOTS-1:0] ring;
    logic                     head_next;
    logic                     pend_valid;
    logic                     act_valid;
    logic                     csm_pend;
    logic                     csm_act;
    fm_pkg::ch_idx_t          pend_ch;
    fm_pkg::ch_idx_t          act_ch;
    logic [3:0]               pend_mask;
    logic [3:0]               act_mask;

    // mask applied while the target channel passes the head
    assign head_next = (act_valid && (slot.ch == act_ch)) ? act_mask[slot.op] : ring[0];

    // forced key-on covers channel 2 for one round only
    assign keyon = ring[0] | (csm_act && (slot.ch == 3'd2));

    always_ff @(posedge clk) begin
        if (reset) begin
            ring       <= '0;
            pend_valid <= 1'b0;
            act_valid  <= 1'b0;
            csm_pend   <= 1'b0;
            csm_act    <= 1'b0;
        end else begin
            ring <= {head_next, ring[`FM_NUM_SLOTS-1:1]};
            if (round_start) begin
                act_valid <= pend_valid;
                csm_act   <= csm_pend;
            end
            if (keyon_wr) begin
                pend_valid <= 1'b1;
            end else if (round_start) begin
                pend_valid <= 1'b0;
            end
            if (csm && overflow_a) begin
                csm_pend <= 1'b1;
            end else if (round_start) begin
                csm_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (keyon_wr) begin
            pend_ch <= keyon_data[2:0];
            // data bits are op1..op4, the mask is in slot order op1 op3 op2 op4
            pend_mask <= {keyon_data[7], keyon_data[5], keyon_data[6], keyon_data[4]};
        end
        if (round_start) begin
            act_ch   <= pend_ch;
            act_mask <= pend_mask;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fm_chan_regs.sv
// Channel parameter ring
`timescale 1ns/1ps
`default_nettype none
`include "fm_config.svh"

module fm_chan_regs (
    input  wire                  clk,
    input  wire                  reset,
    input  wire fm_pkg::slot_t   slot,
    input  wire fm_pkg::update_t upd,
    output fm_pkg::chan_params_t chan_params
);

    // both outputs enabled after reset
    localparam fm_pkg::chan_params_t chan_reset_val = '{
        block: 3'd0,
        fnum:  11'd0,
        fb:    3'd0,
        alg:   3'd0,
        rl:    2'd3,
        ams:   2'd0,
        pms:   3'd0
    };

    fm_pkg::chan_params_t ring [0:`FM_NUM_CH-1];
    fm_pkg::chan_params_t head_next;
    logic                 hit;

    assign chan_params = ring[0];
    // channel registers are shared by all four operators
    assign hit = (upd.target.ch == slot.ch);

    always_comb begin
        head_next = ring[0];
        if (hit) begin
            if (upd.fnum_lo) begin
                // high bits and block come from the earlier A4h write
                head_next.fnum  = {upd.hi_latch[2:0], upd.data};
                head_next.block = upd.hi_latch[5:3];
            end
            if (upd.fb_alg) begin
                head_next.fb  = upd.data[5:3];
                head_next.alg = upd.data[2:0];
            end
            if (upd.pan_mod) begin
                head_next.rl  = upd.data[7:6];
                head_next.ams = upd.data[5:4];
                head_next.pms = upd.data[2:0];
            end
        end
    end

    // ring length equals the channel count so it wraps with the inner loop
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `FM_NUM_CH; i++) begin
                ring[i] <= chan_reset_val;
            end
        end else begin
            for (int i = 0; i < `FM_NUM_CH - 1; i++) begin
                ring[i] <= ring[i+1];
            end
            ring[`FM_NUM_CH-1] <= head_next;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fm_op_regs.sv
// Operator parameter ring
`timescale 1ns/1ps
`default_nettype none
`include "fm_config.svh"

module fm_op_regs (
    input  wire                clk,
    input  wire                reset,
    input  wire fm_pkg::slot_t   slot,
    input  wire fm_pkg::update_t upd,
    output fm_pkg::op_params_t op_params
);

    fm_pkg::op_params_t ring [0:`FM_NUM_SLOTS-1];
    fm_pkg::op_params_t head_next;
    logic               hit;

    // entry 0 always belongs to the slot on the counter
    assign op_params = ring[0];
    assign hit       = (upd.target == slot);

    always_comb begin
        head_next = ring[0];
        if (hit) begin
            if (upd.dt1_mul) begin
                head_next.dt1 = upd.data[6:4];
                head_next.mul = upd.data[3:0];
            end
            if (upd.tl) begin
                head_next.tl = upd.data[6:0];
            end
            if (upd.ks_ar) begin
                head_next.ks = upd.data[7:6];
                head_next.ar = upd.data[4:0];
            end
            if (upd.am_d1r) begin
                head_next.amen = upd.data[7];
                head_next.d1r  = upd.data[4:0];
            end
            if (upd.d2r) begin
                head_next.d2r = upd.data[4:0];
            end
            if (upd.sl_rr) begin
                head_next.sl = upd.data[7:4];
                head_next.rr = upd.data[3:0];
            end
            if (upd.ssg) begin
                head_next.ssg = upd.data[3:0];
            end
        end
    end

    // head goes back in at the tail, one full round later it is at the head again
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `FM_NUM_SLOTS; i++) begin
                ring[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `FM_NUM_SLOTS - 1; i++) begin
                ring[i] <= ring[i+1];
            end
            ring[`FM_NUM_SLOTS-1] <= head_next;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fm_write_seq.sv
// Host write sequencer
`timescale 1ns/1ps
`default_nettype none
`include "fm_config.svh"

module fm_write_seq (
    input  wire             clk,
    input  wire             reset,
    input  wire             wr,
    input  wire  [8:0]      addr,
    input  wire  [7:0]      din,
    output logic            busy,
    output fm_pkg::update_t upd,
    output logic            keyon_wr,
    output logic [7:0]      keyon_data,
    input  wire             round_start
);

    fm_pkg::seq_state_t state;
    fm_pkg::slot_t      dec_target;
    logic [9:0]         dec_strobes;
    logic [9:0]         pend;
    logic [9:0]         strobes;
    logic               accept;
    logic               is_key;
    logic               is_hi;

    assign accept = wr && (state == fm_pkg::seq_idle);
    assign busy   = (state != fm_pkg::seq_idle);
    assign is_key = (addr[7:0] == `FM_ADDR_KEYON);
    assign is_hi  = ({addr[7:2], 2'b00} == `FM_ADDR_FNUM_HI);

    // operator offset 0/4/8/C lines up with the slot op code
    assign dec_target.op = addr[3:2];
    assign dec_target.ch = {addr[8], addr[1:0]};

    always_comb begin
        dec_strobes = '0;
        case (addr[7:4])
            `FM_GRP_DT1_MUL: dec_strobes[9] = 1'b1;
            `FM_GRP_TL:      dec_strobes[8] = 1'b1;
            `FM_GRP_KS_AR:   dec_strobes[7] = 1'b1;
            `FM_GRP_AM_D1R:  dec_strobes[6] = 1'b1;
            `FM_GRP_D2R:     dec_strobes[5] = 1'b1;
            `FM_GRP_SL_RR:   dec_strobes[4] = 1'b1;
            `FM_GRP_SSG:     dec_strobes[3] = 1'b1;
            default: begin
                dec_strobes[2] = ({addr[7:2], 2'b00} == `FM_ADDR_FNUM_LO);
                dec_strobes[1] = ({addr[7:2], 2'b00} == `FM_ADDR_FB_ALG);
                dec_strobes[0] = ({addr[7:2], 2'b00} == `FM_ADDR_PAN_MOD);
            end
        endcase
    end

    assign strobes = {upd.dt1_mul, upd.tl, upd.ks_ar, upd.am_d1r, upd.d2r,
                      upd.sl_rr, upd.ssg, upd.fnum_lo, upd.fb_alg, upd.pan_mod};

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= fm_pkg::seq_idle;
            upd      <= '0;
            keyon_wr <= 1'b0;
        end else begin
            keyon_wr <= accept && is_key;
            case (state)
                fm_pkg::seq_idle: begin
                    if (accept && is_hi) begin
                        upd.hi_latch <= din;
                    end else if (accept && !is_key) begin
                        upd.target <= dec_target;
                        upd.data   <= din;
                        state      <= fm_pkg::seq_armed;
                    end
                end
                fm_pkg::seq_armed: begin
                    if (round_start) begin
                        {upd.dt1_mul, upd.tl, upd.ks_ar, upd.am_d1r, upd.d2r,
                         upd.sl_rr, upd.ssg, upd.fnum_lo, upd.fb_alg,
                         upd.pan_mod} <= pend;
                        state <= fm_pkg::seq_sweep;
                    end
                end
                default: begin
                    // a full round has passed the heads
                    if (round_start) begin
                        {upd.dt1_mul, upd.tl, upd.ks_ar, upd.am_d1r, upd.d2r,
                         upd.sl_rr, upd.ssg, upd.fnum_lo, upd.fb_alg,
                         upd.pan_mod} <= '0;
                        state <= fm_pkg::seq_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pend       <= dec_strobes;
            keyon_data <= din;
        end
    end

    a_one_strobe: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(strobes)
    );

endmodule

`default_nettype wire

//--- rtl/fm_slot_counter.sv
// Operator slot counter
`timescale 1ns/1ps
`default_nettype none
`include "fm_config.svh"

module fm_slot_counter (
    input  wire           clk,
    input  wire           reset,
    output fm_pkg::slot_t slot,
    output logic          round_start
);

    fm_pkg::slot_t slot_next;

    // channel is the inner loop: 0 1 2 4 5 6, then the next operator
    always_comb begin
        slot_next = slot;
        if (slot.ch == 3'd6) begin
            slot_next.ch = 3'd0;
            slot_next.op = slot.op + 2'd1;
        end else if (slot.ch[1:0] == 2'd2) begin
            slot_next.ch = slot.ch + 3'd2;
        end else begin
            slot_next.ch = slot.ch + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            slot <= '0;
        end else begin
            slot <= slot_next;
        end
    end

    // first slot of the round is op1 of channel 0
    assign round_start = (slot.op == 2'd0) && (slot.ch == 3'd0);

    // unused channel codes never reach the ring heads
    a_ch_code_valid: assert property (
        @(posedge clk) disable iff (reset)
        slot.ch[1:0] != 2'b11
    );

    // one round is exactly the slot count long
    a_round_period: assert property (
        @(posedge clk) disable iff (reset)
        round_start |=> !round_start [* (`FM_NUM_SLOTS - 1)] ##1 round_start
    );

endmodule

`default_nettype wire

//--- rtl/fm_pkg.sv
// FM register bank types
`default_nettype none

package fm_pkg;

    // operator slot code, 0=op1 1=op3 2=op2 3=op4
    typedef logic [1:0] op_idx_t;
    // channel code, bit 2 selects the register bank part
    typedef logic [2:0] ch_idx_t;

    typedef struct packed {
        op_idx_t op;
        ch_idx_t ch;
    } slot_t;

    typedef logic [10:0] fnum_t;
    typedef logic [2:0]  block_t;

    typedef struct packed {
        logic [2:0] dt1;
        logic [3:0] mul;
        logic [6:0] tl;
        logic [1:0] ks;
        logic [4:0] ar;
        logic       amen;
        logic [4:0] d1r;
        logic [4:0] d2r;
        logic [3:0] sl;
        logic [3:0] rr;
        logic [3:0] ssg;
    } op_params_t;

    typedef struct packed {
        block_t     block;
        fnum_t      fnum;
        logic [2:0] fb;
        logic [2:0] alg;
        logic [1:0] rl;
        logic [1:0] ams;
        logic [2:0] pms;
    } chan_params_t;

    // one strobe per register group, then the write payload
    typedef struct packed {
        logic       dt1_mul;
        logic       tl;
        logic       ks_ar;
        logic       am_d1r;
        logic       d2r;
        logic       sl_rr;
        logic       ssg;
        logic       fnum_lo;
        logic       fb_alg;
        logic       pan_mod;
        slot_t      target;
        logic [7:0] data;
        // block and fnum high bits from the A4h write
        logic [7:0] hi_latch;
    } update_t;

    typedef enum logic [1:0] {
        seq_idle,
        seq_armed,
        seq_sweep
    } seq_state_t;

endpackage

`default_nettype wire

//--- rtl/fm_config.svh
// FM register bank configuration
`ifndef FM_CONFIG_SVH
`define FM_CONFIG_SVH

// channel and slot counts
`define FM_NUM_CH    6
`define FM_NUM_SLOTS 24

// operator register groups, upper address nibble
`define FM_GRP_DT1_MUL 4'h3
`define FM_GRP_TL      4'h4
`define FM_GRP_KS_AR   4'h5
`define FM_GRP_AM_D1R  4'h6
`define FM_GRP_D2R     4'h7
`define FM_GRP_SL_RR   4'h8
`define FM_GRP_SSG     4'h9

// key-on and channel register addresses
`define FM_ADDR_KEYON   8'h28
`define FM_ADDR_FNUM_LO 8'hA0
`define FM_ADDR_FNUM_HI 8'hA4
`define FM_ADDR_FB_ALG  8'hB0
`define FM_ADDR_PAN_MOD 8'hB4

`endif
